// ==== bench/coh_assertions.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bus protocol assertions, bound into the bus controller
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module coh_assertions (
    input logic CLK,
    input logic arst_n,
    input logic gnt0,
    input logic gnt1,
    input logic snp0,
    input logic snp1,
    input logic done0,
    input logic done1,
    input logic mem_req
);

    // One owner of the bus at a time
    assert property (@(posedge CLK) disable iff (!arst_n) !(gnt0 && gnt1))
        else $error("both caches granted at once");

    // Snoops belong to a granted transaction
    assert property (@(posedge CLK) disable iff (!arst_n) (snp0 || snp1) |-> (gnt0 || gnt1))
        else $error("snoop issued with no grant held");

    assert property (@(posedge CLK) disable iff (!arst_n) done0 |-> gnt0)
        else $error("done to cache 0 without its grant");

    assert property (@(posedge CLK) disable iff (!arst_n) done1 |-> gnt1)
        else $error("done to cache 1 without its grant");

    // Memory stays quiet right after reset
    assert property (@(posedge CLK) $rose(arst_n) |-> !mem_req)
        else $error("memory request in the first cycle after reset");

endmodule

bind coh_bus_ctrl coh_assertions chk (
    .CLK     (CLK),
    .arst_n  (arst_n),
    .gnt0    (bus0.gnt),
    .gnt1    (bus1.gnt),
    .snp0    (bus0.snp_valid),
    .snp1    (bus1.snp_valid),
    .done0   (bus0.done),
    .done1   (bus1.done),
    .mem_req (mem_req)
);

`default_nettype wire

// ==== bench/coh_testdata.txt ====
// Columns: cpu, write flag, address, write data, expected read data (hex)
// Expected data is checked on reads only, a cpu of ff ends the list
// Reads after reset see zero
0 0 0010 00000000 00000000
1 0 0021 00000000 00000000
0 0 0103 00000000 00000000
// Write hit in E, then read back
0 1 0010 11112222 00000000
0 0 0010 00000000 11112222
// Shared line, upgrade, read back, evicted 0010 seen from cpu1
1 0 0030 00000000 00000000
0 0 0030 00000000 00000000
0 1 0030 33334444 00000000
0 0 0030 00000000 33334444
1 0 0010 00000000 11112222
// Dirty peer supplies data
0 1 0045 a5a5a5a5 00000000
1 0 0045 00000000 a5a5a5a5
0 0 0045 00000000 a5a5a5a5
// Both share, cpu1 upgrades, cpu0 rereads
0 0 0056 00000000 00000000
1 0 0056 00000000 00000000
1 1 0056 5a5a0001 00000000
0 0 0056 00000000 5a5a0001
// Same index, dirty victim written back
0 1 0067 12340067 00000000
0 1 0167 56780167 00000000
1 0 0067 00000000 12340067
0 0 0167 00000000 56780167
ff 00 0000 00000000 00000000

// ==== bench/tb_coh_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the two-processor coherence subsystem
// Replays the testdata list, then runs both CPUs at once on disjoint random addresses
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none
`include "coh_consts.svh"

module tb_coh_top;

    localparam int MAX_OPS = 64;
    localparam int FIELDS  = 5;
    localparam int N_RAND  = 24;

    logic                   CLK = 1'b0;
    logic                   arst_n;
    logic                   cpu0_req;
    logic                   cpu0_we;
    logic [`COH_ADDR_W-1:0] cpu0_addr;
    logic [`COH_DATA_W-1:0] cpu0_wdata;
    logic [`COH_DATA_W-1:0] cpu0_rdata;
    logic                   cpu0_done;
    logic                   cpu1_req;
    logic                   cpu1_we;
    logic [`COH_ADDR_W-1:0] cpu1_addr;
    logic [`COH_DATA_W-1:0] cpu1_wdata;
    logic [`COH_DATA_W-1:0] cpu1_rdata;
    logic                   cpu1_done;

    // Five words per operation: cpu, write flag, address, write data, expected read
    logic [31:0] td [0:MAX_OPS*FIELDS-1];

    // Reference memory, only words written so far, the rest read as zero
    logic [`COH_DATA_W-1:0] ref_mem [logic [`COH_ADDR_W-1:0]];

    // Random phase stimulus per CPU
    logic                   rnd_we    [2][N_RAND];
    logic [`COH_ADDR_W-1:0] rnd_addr  [2][N_RAND];
    logic [`COH_DATA_W-1:0] rnd_wdata [2][N_RAND];

    int err_cnt;
    int file_ops;
    int limit_cycles;

    always #20 CLK = ~CLK;

    coh_top uut (
        .CLK        (CLK),
        .arst_n     (arst_n),
        .cpu0_req   (cpu0_req),
        .cpu0_we    (cpu0_we),
        .cpu0_addr  (cpu0_addr),
        .cpu0_wdata (cpu0_wdata),
        .cpu0_rdata (cpu0_rdata),
        .cpu0_done  (cpu0_done),
        .cpu1_req   (cpu1_req),
        .cpu1_we    (cpu1_we),
        .cpu1_addr  (cpu1_addr),
        .cpu1_wdata (cpu1_wdata),
        .cpu1_rdata (cpu1_rdata),
        .cpu1_done  (cpu1_done)
    );

    function automatic logic [`COH_DATA_W-1:0] expected_read(
        input logic [`COH_ADDR_W-1:0] addr
    );
        if (ref_mem.exists(addr)) begin
            return ref_mem[addr];
        end
        return '0;
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        if (exp !== act) begin
            err_cnt++;
            $display("FAIL %s expected %h actual %h", name, exp, act);
            $display("Errors found");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    // One processor access, held until done, then checked against the reference
    task automatic run_op(
        input  string                  name,
        input  int                     cpu,
        input  logic                   we,
        input  logic [`COH_ADDR_W-1:0] addr,
        input  logic [`COH_DATA_W-1:0] wdata,
        output logic [`COH_DATA_W-1:0] rdata
    );
        @(posedge CLK);
        if (cpu == 0) begin
            cpu0_req   <= 1'b1;
            cpu0_we    <= we;
            cpu0_addr  <= addr;
            cpu0_wdata <= wdata;
        end else begin
            cpu1_req   <= 1'b1;
            cpu1_we    <= we;
            cpu1_addr  <= addr;
            cpu1_wdata <= wdata;
        end
        // Done lasts one cycle, look at it mid-cycle
        do begin
            @(negedge CLK);
        end while (!((cpu == 0) ? cpu0_done : cpu1_done));
        rdata = (cpu == 0) ? cpu0_rdata : cpu1_rdata;
        // Reference follows completion order
        if (we) begin
            ref_mem[addr] = wdata;
        end else begin
            check_value({name, " ref"}, expected_read(addr), rdata);
        end
        @(posedge CLK);
        if (cpu == 0) begin
            cpu0_req <= 1'b0;
        end else begin
            cpu1_req <= 1'b0;
        end
    endtask

    task automatic run_random(input int cpu);
        logic [`COH_DATA_W-1:0] rdata;
        for (int i = 0; i < N_RAND; i++) begin
            run_op($sformatf("rand cpu%0d op%0d", cpu, i), cpu, rnd_we[cpu][i],
                   rnd_addr[cpu][i], rnd_wdata[cpu][i], rdata);
        end
    endtask

    // Run limit scales with the number of operations
    initial begin : watchdog
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge CLK);
        $display("Timeout: requests still pending after %0d cycles", limit_cycles);
        $display("Errors found");
        $fatal(1, "watchdog expired");
    end

    initial begin : main
        logic [`COH_DATA_W-1:0] rdata;
        logic [31:0]            r;
        logic [`COH_ADDR_W-1:0] base_addr;
        string                  name;
        int                     base;
        arst_n     = 1'b0;
        cpu0_req   = 1'b0;
        cpu0_we    = 1'b0;
        cpu0_addr  = '0;
        cpu0_wdata = '0;
        cpu1_req   = 1'b0;
        cpu1_we    = 1'b0;
        cpu1_addr  = '0;
        cpu1_wdata = '0;
        err_cnt      = 0;
        file_ops     = 0;
        limit_cycles = 0;
        void'($urandom(32'ha25c));

        // Unused slots read as the end marker
        for (int i = 0; i < MAX_OPS * FIELDS; i++) begin
            td[i] = 32'hff;
        end
        $readmemh("bench/coh_testdata.txt", td);
        while ((file_ops < MAX_OPS) && (td[file_ops * FIELDS] != 32'hff)) begin
            file_ops++;
        end

        // Sixteen words per CPU over eight lines, so evictions happen
        for (int c = 0; c < 2; c++) begin
            base_addr = (c == 0) ? 16'h2000 : 16'h3000;
            for (int i = 0; i < N_RAND; i++) begin
                r = $urandom;
                rnd_we[c][i]    = r[0];
                rnd_addr[c][i]  = base_addr | {12'h000, r[4:1]};
                rnd_wdata[c][i] = $urandom;
            end
        end
        limit_cycles = (file_ops + 2 * N_RAND) * 40;

        repeat (10) @(posedge CLK);
        arst_n <= 1'b1;
        @(posedge CLK);

        // Directed sequence from the data file
        for (int i = 0; i < file_ops; i++) begin
            base = i * FIELDS;
            name = $sformatf("line%0d cpu%0d %s %h", i, td[base][0],
                             td[base + 1][0] ? "wr" : "rd", td[base + 2][15:0]);
            run_op(name, int'(td[base][0]), td[base + 1][0],
                   td[base + 2][`COH_ADDR_W-1:0], td[base + 3], rdata);
            if (!td[base + 1][0]) begin
                check_value({name, " file"}, td[base + 4], rdata);
            end
        end

        // Both CPUs at once, arbiter under load
        fork
            run_random(0);
            run_random(1);
        join

        if (err_cnt == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== coh_top.f ====
+incdir+include
design/coh_pkg.sv
design/coh_bus_if.sv
design/l1_mesi_cache.sv
design/coh_bus_ctrl.sv
design/coh_mem.sv
design/coh_top.sv
bench/coh_assertions.sv
bench/tb_coh_top.sv

// ==== design/coh_bus_ctrl.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Coherence bus controller
// Round-robin grant, snoop broadcast, peer or memory data, writebacks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none
`include "coh_consts.svh"

module coh_bus_ctrl (
    input  logic                   CLK,
    input  logic                   arst_n,
    coh_bus_if.ctrl                bus0,
    coh_bus_if.ctrl                bus1,
    output logic                   mem_req,
    output logic                   mem_we,
    output logic [`COH_ADDR_W-1:0] mem_addr,
    output logic [`COH_DATA_W-1:0] mem_wdata,
    input  logic [`COH_DATA_W-1:0] mem_rdata,
    input  logic                   mem_ack
);

    localparam int N     = `COH_NUM_CACHES;
    localparam int OWN_W = (N > 1) ? $clog2(N) : 1;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_SNOOP,
        ST_WAIT_RESP,
        ST_MEMORY,
        ST_FINISH
    } xact_e;

    xact_e st_q;

    // Per-cache views of the two links
    logic [N-1:0]           req_v;
    logic [N-1:0]           hit_v;
    logic [N-1:0]           dirty_v;
    coh_pkg::bus_cmd_e      cmd_v   [N];
    coh_pkg::coh_addr_u     addr_v  [N];
    logic [`COH_DATA_W-1:0] wdata_v [N];
    logic [`COH_DATA_W-1:0] sdata_v [N];

    logic [OWN_W-1:0] prio_q;
    logic [OWN_W-1:0] owner_q;
    logic [OWN_W-1:0] pick;
    logic             pick_vld;
    logic             gnt_q;
    logic             shared_q;
    logic [`COH_DATA_W-1:0] rdata_q;

    coh_pkg::bus_cmd_e      cmd_cur;
    coh_pkg::coh_addr_u     addr_cur;
    logic                   peer_hit;
    logic                   peer_dirty;
    logic [`COH_DATA_W-1:0] peer_data;
    logic                   snoop_phase;
    logic                   fin;

    always_comb begin
        req_v[0]   = bus0.req;
        req_v[1]   = bus1.req;
        hit_v[0]   = bus0.snp_hit;
        hit_v[1]   = bus1.snp_hit;
        dirty_v[0] = bus0.snp_dirty;
        dirty_v[1] = bus1.snp_dirty;
        cmd_v[0]   = bus0.cmd;
        cmd_v[1]   = bus1.cmd;
        addr_v[0]  = bus0.addr;
        addr_v[1]  = bus1.addr;
        wdata_v[0] = bus0.wdata;
        wdata_v[1] = bus1.wdata;
        sdata_v[0] = bus0.snp_data;
        sdata_v[1] = bus1.snp_data;
    end

    assign cmd_cur  = cmd_v[owner_q];
    assign addr_cur = addr_v[owner_q];

    // First requester at or after the priority pointer
    always_comb begin
        int cand;
        pick     = prio_q;
        pick_vld = 1'b0;
        for (int k = N - 1; k >= 0; k--) begin
            cand = (int'(prio_q) + k) % N;
            if (req_v[cand]) begin
                pick     = OWN_W'(cand);
                pick_vld = 1'b1;
            end
        end
    end

    // Merge snoop answers from every non-owner
    always_comb begin
        peer_hit   = 1'b0;
        peer_dirty = 1'b0;
        peer_data  = '0;
        for (int i = 0; i < N; i++) begin
            if (i != int'(owner_q)) begin
                peer_hit = peer_hit | hit_v[i];
                if (dirty_v[i]) begin
                    peer_dirty = 1'b1;
                    peer_data  = sdata_v[i];
                end
            end
        end
    end

    // Writebacks never snoop
    assign snoop_phase = (st_q == ST_SNOOP) && (cmd_cur != coh_pkg::BUS_WB);
    assign fin         = (st_q == ST_FINISH);

    // Transaction FSM
    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            st_q     <= ST_IDLE;
            gnt_q    <= 1'b0;
            prio_q   <= '0;
            owner_q  <= '0;
            shared_q <= 1'b0;
            mem_req  <= 1'b0;
            mem_we   <= 1'b0;
        end else begin
            mem_req <= 1'b0;
            case (st_q)
                ST_IDLE: begin
                    if (pick_vld) begin
                        owner_q <= pick;
                        gnt_q   <= 1'b1;
                        st_q    <= ST_SNOOP;
                    end
                end
                ST_SNOOP: begin
                    if (cmd_cur == coh_pkg::BUS_WB) begin
                        mem_req <= 1'b1;
                        mem_we  <= 1'b1;
                        st_q    <= ST_MEMORY;
                    end else begin
                        st_q <= ST_WAIT_RESP;
                    end
                end
                ST_WAIT_RESP: begin
                    shared_q <= peer_hit;
                    if (cmd_cur == coh_pkg::BUS_UPG) begin
                        st_q <= ST_FINISH;
                    end else begin
                        // Dirty peer data also goes to memory
                        mem_req <= 1'b1;
                        mem_we  <= peer_dirty;
                        st_q    <= ST_MEMORY;
                    end
                end
                ST_MEMORY: begin
                    if (mem_ack) begin
                        st_q <= ST_FINISH;
                    end
                end
                default: begin
                    // Done pulse, then rotate past the owner
                    gnt_q  <= 1'b0;
                    prio_q <= OWN_W'((int'(owner_q) + 1) % N);
                    st_q   <= ST_IDLE;
                end
            endcase
        end
    end

    // Memory payload and returned data
    always_ff @(posedge CLK) begin
        if (st_q == ST_SNOOP) begin
            mem_addr  <= addr_cur.raw;
            mem_wdata <= wdata_v[owner_q];
        end
        if (st_q == ST_WAIT_RESP) begin
            mem_wdata <= peer_data;
            rdata_q   <= peer_data;
        end
        if ((st_q == ST_MEMORY) && mem_ack && !mem_we) begin
            rdata_q <= mem_rdata;
        end
    end

    // Link outputs
    assign bus0.gnt       = gnt_q && (owner_q == OWN_W'(0));
    assign bus0.done      = fin && (owner_q == OWN_W'(0));
    assign bus0.rdata     = rdata_q;
    assign bus0.shared    = shared_q;
    assign bus0.snp_valid = snoop_phase && (owner_q != OWN_W'(0));
    assign bus0.snp_cmd   = cmd_cur;
    assign bus0.snp_addr  = addr_cur;

    assign bus1.gnt       = gnt_q && (owner_q == OWN_W'(1));
    assign bus1.done      = fin && (owner_q == OWN_W'(1));
    assign bus1.rdata     = rdata_q;
    assign bus1.shared    = shared_q;
    assign bus1.snp_valid = snoop_phase && (owner_q != OWN_W'(1));
    assign bus1.snp_cmd   = cmd_cur;
    assign bus1.snp_addr  = addr_cur;

endmodule

`default_nettype wire

// ==== design/coh_bus_if.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// One cache's link to the bus controller
// Request and grant, snoop in and out, and data both ways
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none
`include "coh_consts.svh"

interface coh_bus_if;

    // Master side, held by the cache until done
    logic                   req;
    coh_pkg::bus_cmd_e      cmd;
    coh_pkg::coh_addr_u     addr;
    logic [`COH_DATA_W-1:0] wdata;
    logic                   gnt;
    logic                   done;
    logic [`COH_DATA_W-1:0] rdata;
    logic                   shared;

    // Snoop side, answered one cycle after snp_valid
    logic                   snp_valid;
    coh_pkg::bus_cmd_e      snp_cmd;
    coh_pkg::coh_addr_u     snp_addr;
    logic                   snp_hit;
    logic                   snp_dirty;
    logic [`COH_DATA_W-1:0] snp_data;

    modport cache (
        output req, cmd, addr, wdata, snp_hit, snp_dirty, snp_data,
        input  gnt, done, rdata, shared, snp_valid, snp_cmd, snp_addr
    );

    modport ctrl (
        input  req, cmd, addr, wdata, snp_hit, snp_dirty, snp_data,
        output gnt, done, rdata, shared, snp_valid, snp_cmd, snp_addr
    );

endinterface

`default_nettype wire

// ==== design/coh_mem.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Word-addressed backing memory
// One request per access, ack after a fixed latency
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none
`include "coh_consts.svh"

module coh_mem (
    input  logic                   CLK,
    input  logic                   arst_n,
    input  logic                   mem_req,
    input  logic                   mem_we,
    input  logic [`COH_ADDR_W-1:0] mem_addr,
    input  logic [`COH_DATA_W-1:0] mem_wdata,
    output logic [`COH_DATA_W-1:0] mem_rdata,
    output logic                   mem_ack
);

    localparam int DEPTH = 1 << `COH_ADDR_W;
    localparam int CNT_W = $clog2(`COH_MEM_LAT + 1);

    logic [`COH_DATA_W-1:0] mem_q [DEPTH];
    logic [CNT_W-1:0]       lat_cnt;

    // Array starts at zero, writes land at request time
    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            lat_cnt <= '0;
            for (int i = 0; i < DEPTH; i++) begin
                mem_q[i] <= '0;
            end
        end else begin
            if (mem_req) begin
                lat_cnt <= CNT_W'(`COH_MEM_LAT);
                if (mem_we) begin
                    mem_q[mem_addr] <= mem_wdata;
                end
            end else if (lat_cnt != '0) begin
                lat_cnt <= lat_cnt - 1'b1;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (mem_req && !mem_we) begin
            mem_rdata <= mem_q[mem_addr];
        end
    end

    // Last count step is the ack cycle
    assign mem_ack = (lat_cnt == CNT_W'(1));

endmodule

`default_nettype wire

// ==== design/coh_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared types for the snoopy MESI caches and bus controller
// Referenced by scoped name from the RTL and the bench
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`include "coh_consts.svh"

package coh_pkg;

    // Line state per cache entry
    typedef enum logic [1:0] {
        INVALID   = 2'b00,
        SHARED    = 2'b01,
        EXCLUSIVE = 2'b10,
        MODIFIED  = 2'b11
    } mesi_e;

    // Commands on the coherence bus
    typedef enum logic [1:0] {
        BUS_RD  = 2'b00,   // read to share
        BUS_RDX = 2'b01,   // read to own
        BUS_UPG = 2'b10,   // invalidate peers, no data
        BUS_WB  = 2'b11    // dirty line back to memory
    } bus_cmd_e;

    // Tag and index split of a word address
    typedef struct packed {
        logic [`COH_TAG_W-1:0]   tag;
        logic [`COH_INDEX_W-1:0] index;
    } addr_fields_s;

    // Raw word for the bus and memory, fields for the cache arrays
    typedef union packed {
        logic [`COH_ADDR_W-1:0] raw;
        addr_fields_s           fields;
    } coh_addr_u;

endpackage

`default_nettype wire

// ==== design/coh_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Two-processor snoopy coherence subsystem
// Two L1 caches, bus controller and memory behind plain CPU ports
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none
`include "coh_consts.svh"

module coh_top (
    input  logic                   CLK,
    input  logic                   arst_n,
    // Processor 0
    input  logic                   cpu0_req,
    input  logic                   cpu0_we,
    input  logic [`COH_ADDR_W-1:0] cpu0_addr,
    input  logic [`COH_DATA_W-1:0] cpu0_wdata,
    output logic [`COH_DATA_W-1:0] cpu0_rdata,
    output logic                   cpu0_done,
    // Processor 1
    input  logic                   cpu1_req,
    input  logic                   cpu1_we,
    input  logic [`COH_ADDR_W-1:0] cpu1_addr,
    input  logic [`COH_DATA_W-1:0] cpu1_wdata,
    output logic [`COH_DATA_W-1:0] cpu1_rdata,
    output logic                   cpu1_done
);

    // Cache to controller links
    coh_bus_if bus0 ();
    coh_bus_if bus1 ();

    // Controller to memory
    logic                   mem_req;
    logic                   mem_we;
    logic [`COH_ADDR_W-1:0] mem_addr;
    logic [`COH_DATA_W-1:0] mem_wdata;
    logic [`COH_DATA_W-1:0] mem_rdata;
    logic                   mem_ack;

    l1_mesi_cache cache0 (
        .CLK       (CLK),
        .arst_n    (arst_n),
        .cpu_req   (cpu0_req),
        .cpu_we    (cpu0_we),
        .cpu_addr  (cpu0_addr),
        .cpu_wdata (cpu0_wdata),
        .cpu_rdata (cpu0_rdata),
        .cpu_done  (cpu0_done),
        .bus       (bus0.cache)
    );

    l1_mesi_cache cache1 (
        .CLK       (CLK),
        .arst_n    (arst_n),
        .cpu_req   (cpu1_req),
        .cpu_we    (cpu1_we),
        .cpu_addr  (cpu1_addr),
        .cpu_wdata (cpu1_wdata),
        .cpu_rdata (cpu1_rdata),
        .cpu_done  (cpu1_done),
        .bus       (bus1.cache)
    );

    coh_bus_ctrl bus_ctrl (
        .CLK       (CLK),
        .arst_n    (arst_n),
        .bus0      (bus0.ctrl),
        .bus1      (bus1.ctrl),
        .mem_req   (mem_req),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata),
        .mem_ack   (mem_ack)
    );

    coh_mem mem (
        .CLK       (CLK),
        .arst_n    (arst_n),
        .mem_req   (mem_req),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata),
        .mem_ack   (mem_ack)
    );

endmodule

`default_nettype wire

// ==== design/l1_mesi_cache.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Direct-mapped L1 data cache with MESI line states
// Processor strobe port in, coherence bus master and snoop responder out
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none
`include "coh_consts.svh"

module l1_mesi_cache (
    input  logic                   CLK,
    input  logic                   arst_n,
    input  logic                   cpu_req,
    input  logic                   cpu_we,
    input  coh_pkg::coh_addr_u     cpu_addr,
    input  logic [`COH_DATA_W-1:0] cpu_wdata,
    output logic [`COH_DATA_W-1:0] cpu_rdata,
    output logic                   cpu_done,
    coh_bus_if.cache               bus
);

    localparam int LINES = 1 << `COH_INDEX_W;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_WRITEBACK,
        ST_FILL,
        ST_UPGRADE,
        ST_RESPOND
    } ctl_e;

    ctl_e ctl_q;

    // Line arrays
    logic [`COH_TAG_W-1:0]  tag_q   [LINES];
    logic [`COH_DATA_W-1:0] data_q  [LINES];
    coh_pkg::mesi_e         state_q [LINES];

    // Captured processor request
    coh_pkg::coh_addr_u     req_addr;
    logic                   req_we;
    logic [`COH_DATA_W-1:0] req_wdata;
    logic [`COH_DATA_W-1:0] rdata_q;

    logic [`COH_INDEX_W-1:0] idx;
    coh_pkg::mesi_e          line_st;
    logic                    hit;
    logic                    lookup_go;
    logic                    bus_fin;
    logic                    fill_fin;
    coh_pkg::coh_addr_u      victim_addr;

    // Snoop lookup
    logic [`COH_INDEX_W-1:0] sidx;
    logic                    snp_hit_c;

    assign idx     = req_addr.fields.index;
    assign line_st = state_q[idx];
    assign hit     = (line_st != coh_pkg::INVALID) && (tag_q[idx] == req_addr.fields.tag);

    // Lookup waits a cycle if a snoop lands on the same cycle
    assign lookup_go = (ctl_q == ST_LOOKUP) && !bus.snp_valid;
    assign bus_fin   = bus.gnt && bus.done;
    assign fill_fin  = bus_fin && ((ctl_q == ST_FILL) || (ctl_q == ST_UPGRADE));

    assign sidx      = bus.snp_addr.fields.index;
    assign snp_hit_c = (state_q[sidx] != coh_pkg::INVALID) &&
                       (tag_q[sidx] == bus.snp_addr.fields.tag);

    assign cpu_rdata = rdata_q;
    assign cpu_done  = (ctl_q == ST_RESPOND);

    // Bus request follows the FSM state
    always_comb begin
        victim_addr.fields.tag   = tag_q[idx];
        victim_addr.fields.index = idx;
        bus.req   = 1'b0;
        bus.cmd   = coh_pkg::BUS_RD;
        bus.addr  = req_addr;
        bus.wdata = data_q[idx];
        case (ctl_q)
            ST_WRITEBACK: begin
                bus.req  = 1'b1;
                bus.cmd  = coh_pkg::BUS_WB;
                bus.addr = victim_addr;
            end
            ST_FILL: begin
                bus.req = 1'b1;
                bus.cmd = req_we ? coh_pkg::BUS_RDX : coh_pkg::BUS_RD;
            end
            ST_UPGRADE: begin
                bus.req = 1'b1;
                bus.cmd = coh_pkg::BUS_UPG;
            end
            default: begin
                bus.req = 1'b0;
            end
        endcase
    end

    // Control FSM, line states and snoop response flags
    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            ctl_q         <= ST_IDLE;
            bus.snp_hit   <= 1'b0;
            bus.snp_dirty <= 1'b0;
            for (int i = 0; i < LINES; i++) begin
                state_q[i] <= coh_pkg::INVALID;
            end
        end else begin
            case (ctl_q)
                ST_IDLE: begin
                    if (cpu_req) begin
                        ctl_q <= ST_LOOKUP;
                    end
                end
                ST_LOOKUP: begin
                    if (lookup_go) begin
                        if (hit && !req_we) begin
                            ctl_q <= ST_RESPOND;
                        end else if (hit && (line_st != coh_pkg::SHARED)) begin
                            // Silent E to M
                            state_q[idx] <= coh_pkg::MODIFIED;
                            ctl_q        <= ST_RESPOND;
                        end else if (hit) begin
                            ctl_q <= ST_UPGRADE;
                        end else if (line_st == coh_pkg::MODIFIED) begin
                            ctl_q <= ST_WRITEBACK;
                        end else begin
                            ctl_q <= ST_FILL;
                        end
                    end
                end
                ST_WRITEBACK: begin
                    if (bus_fin) begin
                        state_q[idx] <= coh_pkg::INVALID;
                        ctl_q        <= ST_FILL;
                    end
                end
                ST_FILL: begin
                    if (bus_fin) begin
                        if (req_we) begin
                            state_q[idx] <= coh_pkg::MODIFIED;
                        end else if (bus.shared) begin
                            state_q[idx] <= coh_pkg::SHARED;
                        end else begin
                            state_q[idx] <= coh_pkg::EXCLUSIVE;
                        end
                        ctl_q <= ST_RESPOND;
                    end
                end
                ST_UPGRADE: begin
                    // Peers are invalid now, the full word is ours
                    if (bus_fin) begin
                        state_q[idx] <= coh_pkg::MODIFIED;
                        ctl_q        <= ST_RESPOND;
                    end
                end
                default: begin
                    ctl_q <= ST_IDLE;
                end
            endcase

            // Snoops only arrive while this cache is not granted
            if (bus.snp_valid) begin
                bus.snp_hit   <= snp_hit_c;
                bus.snp_dirty <= snp_hit_c && (state_q[sidx] == coh_pkg::MODIFIED);
                if (snp_hit_c) begin
                    if (bus.snp_cmd == coh_pkg::BUS_RD) begin
                        state_q[sidx] <= coh_pkg::SHARED;
                    end else begin
                        state_q[sidx] <= coh_pkg::INVALID;
                    end
                end
            end
        end
    end

    // Request capture, tag and data arrays, snoop data
    always_ff @(posedge CLK) begin
        if ((ctl_q == ST_IDLE) && cpu_req) begin
            req_addr  <= cpu_addr;
            req_we    <= cpu_we;
            req_wdata <= cpu_wdata;
        end
        if (lookup_go && hit) begin
            rdata_q <= data_q[idx];
            if (req_we && (line_st != coh_pkg::SHARED)) begin
                data_q[idx] <= req_wdata;
            end
        end
        if (fill_fin) begin
            tag_q[idx]  <= req_addr.fields.tag;
            data_q[idx] <= req_we ? req_wdata : bus.rdata;
            rdata_q     <= bus.rdata;
        end
        if (bus.snp_valid) begin
            bus.snp_data <= data_q[sidx];
        end
    end

endmodule

`default_nettype wire

// ==== include/coh_consts.svh ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Width, sizing and latency constants for the coherence subsystem
// Included by the package, the bus interface and every RTL block
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef COH_CONSTS_SVH
`define COH_CONSTS_SVH

// Processor word address and data widths
`define COH_ADDR_W 16
`define COH_DATA_W 32

// Eight lines per cache, rest of the address is tag
`define COH_INDEX_W 3
`define COH_TAG_W (`COH_ADDR_W - `COH_INDEX_W)

// Cycles from mem_req to mem_ack
`define COH_MEM_LAT 3

// Caches sharing the bus
`define COH_NUM_CACHES 2

`endif

// ==== run_sim.sh ====
#!/bin/sh
# Build the coherence testbench with Verilator, run it, then scan the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert -Wno-fatal --top-module tb_coh_top -f coh_top.f -o sim_coh \
    > build.log 2>&1 || { echo "Verilator build failed, see build.log"; exit 1; }
./obj_dir/sim_coh > sim.log 2>&1 || echo "Errors found" >> sim.log
cat sim.log
grep -q "Errors found" sim.log && { echo "Simulation FAILED"; exit 1; } || echo "Simulation passed"
